// File: Bender.yml
package:
  name: arithmetic_logic_unit

sources:
  - files:
      - logic/aluPkg.sv
      - logic/aluAdder.sv
      - logic/aluLogicUnit.sv
      - logic/aluShifter.sv
      - logic/aluControl.sv
      - logic/arithmeticLogicUnit.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/aluTb.sv

// File: bench/aluPatterns.hex
// columns: a, b, funSel (wide in bit 4, op in bits 3..0), writeFlags,
// expected aluOut, expected flagsOut after the edge (Z C N O, high to low)
00000000 00000000 10 0 00000000 0
12345678 00000000 00 0 00005678 0
ffffffff 00000001 14 1 00000000 c
0000ffff 00000000 05 1 00000000 c
abcd7fff 12340001 04 1 00008000 3
80000000 80000000 14 1 00000000 d
00000001 00000002 15 1 00000004 0
00000001 00000002 16 1 ffffffff 6
80000000 00000001 16 1 7fffffff 1
ffff7fff 0000ffff 06 1 00008000 7
00001234 00001234 06 1 00000000 8
00000001 0000ffff 05 1 00000000 c
7fffffff 00000000 15 1 80000000 3
f0f0f0f0 ff00ff00 17 1 f000f000 3
80000001 00000100 08 1 00000101 1
12340000 00000000 02 1 0000ffff 3
a5a5a5a5 a5a5a5a5 19 1 00000000 9
ffffffff 0000ffff 0a 1 00000000 9
00000000 00000000 13 1 ffffffff 3
00000000 89ab7654 01 1 00007654 1
80000001 00000000 1b 1 00000002 5
00004000 00000000 0e 1 00008001 3
ffff8000 00000000 0b 1 00000000 d
00000002 00000000 0f 1 00008001 3
80000003 00000000 1d 1 c0000001 7
00018002 00000000 0d 1 0000c001 3
00000001 00000000 1c 1 00000000 d
00000000 00000000 1f 1 80000000 3
ffffffff 00000001 14 0 00000000 3
00000000 0000ff00 03 0 000000ff 3

// File: bench/aluModel.svh
/*
  Reference model of the ALU result and the next Z/C/N/O flags.
  Narrow mode works on the low 16 bits and returns a zero upper half.
  Also holds the 32-bit xorshift step for the random vectors.
*/
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

function automatic logic [31:0] xorshiftNext(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic aluPkg::word_t expectedResult(input aluPkg::word_t a,
    input aluPkg::word_t b, input aluPkg::funSel_t fs, input logic carry);
    int            msb;
    aluPkg::word_t mask;
    aluPkg::word_t am;
    aluPkg::word_t bm;
    aluPkg::word_t r;
    msb  = fs.wide ? 31 : 15;
    mask = fs.wide ? 32'hffff_ffff : 32'h0000_ffff;
    am   = a & mask;
    bm   = b & mask;
    case (fs.op)
        aluPkg::opPassA:       r = am;
        aluPkg::opPassB:       r = bm;
        aluPkg::opNotA:        r = ~am;
        aluPkg::opNotB:        r = ~bm;
        aluPkg::opAdd:         r = am + bm;
        aluPkg::opAddCarry:    r = am + bm + {31'b0, carry};
        aluPkg::opSub:         r = am - bm;
        aluPkg::opAnd:         r = am & bm;
        aluPkg::opOr:          r = am | bm;
        aluPkg::opXor:         r = am ^ bm;
        aluPkg::opNand:        r = ~(am & bm);
        aluPkg::opShiftLeft:   r = am << 1;
        aluPkg::opShiftRight:  r = am >> 1;
        // sign bit of the active width stays in place
        aluPkg::opShiftArith:  r = (am >> 1) | ({31'b0, am[msb]} << msb);
        aluPkg::opRotateLeft:  r = (am << 1) | {31'b0, carry};
        aluPkg::opRotateRight: r = (am >> 1) | ({31'b0, carry} << msb);
        default:               r = '0;
    endcase
    return r & mask;
endfunction

function automatic aluPkg::flags_t expectedFlags(input aluPkg::word_t a,
    input aluPkg::word_t b, input aluPkg::funSel_t fs, input aluPkg::flags_t cur);
    int             msb;
    aluPkg::word_t  mask;
    aluPkg::word_t  am;
    aluPkg::word_t  bm;
    aluPkg::word_t  r;
    logic [32:0]    total;
    aluPkg::flags_t next;
    msb  = fs.wide ? 31 : 15;
    mask = fs.wide ? 32'hffff_ffff : 32'h0000_ffff;
    am   = a & mask;
    bm   = b & mask;
    r    = expectedResult(a, b, fs, cur.carry);
    next = cur;
    next.zero     = (r == '0);
    next.negative = r[msb];
    case (fs.op)
        aluPkg::opAdd, aluPkg::opAddCarry:
        begin
            total = {1'b0, am} + {1'b0, bm}
                  + {32'b0, (fs.op == aluPkg::opAddCarry) && cur.carry};
            next.carry    = total[msb + 1];
            next.overflow = (am[msb] == bm[msb]) && (r[msb] != am[msb]);
        end
        aluPkg::opSub:
        begin
            // borrow
            next.carry    = (am < bm);
            next.overflow = (am[msb] != bm[msb]) && (r[msb] == bm[msb]);
        end
        aluPkg::opShiftLeft, aluPkg::opRotateLeft:
            next.carry = am[msb];
        aluPkg::opShiftRight, aluPkg::opShiftArith, aluPkg::opRotateRight:
            next.carry = am[0];
        default:
            next.carry = cur.carry;
    endcase
    return next;
endfunction

`endif

// File: bench/aluTb.sv
/*
  Testbench for the ALU: replays bench/aluPatterns.hex, then 200 xorshift vectors.
  Inputs change 1 ns after the rising edge; aluOut is checked 1 ns before the next edge
  and flagsOut 1 ns after it. Run from the project root so the pattern file is found.
*/
`timescale 1ns/1ps

module aluTb;

    localparam int          ResetCycles  = 10;
    localparam int          PatternCount = 30;
    localparam int          RandomCount  = 200;
    localparam int          WordsPerLine = 6;
    localparam int          GroupCount   = 5;
    localparam logic [31:0] Seed         = 32'h8b3c271d;

    logic            Clock;
    logic            rstN;
    aluPkg::word_t   a;
    aluPkg::word_t   b;
    aluPkg::funSel_t funSel;
    logic            writeFlags;
    aluPkg::word_t   aluOut;
    aluPkg::flags_t  flagsOut;

    logic [31:0]     patternMem [0:PatternCount*WordsPerLine-1];
    string           groupName [GroupCount];
    int              groupLast [GroupCount];
    int              errorCount;
    int              groupErrors;
    int              vectorCount;

    `include "aluModel.svh"

    arithmeticLogicUnit dut_i
    (
        .Clock      (Clock),
        .rstN       (rstN),
        .a          (a),
        .b          (b),
        .funSel     (funSel),
        .writeFlags (writeFlags),
        .aluOut     (aluOut),
        .flagsOut   (flagsOut)
    );

    always #5 Clock = ~Clock;

    // called 1 ns after an edge, returns 1 ns after the next one
    task automatic applyVector(input string name, input aluPkg::word_t va, input aluPkg::word_t vb,
        input aluPkg::funSel_t vf, input logic vw, input aluPkg::word_t wantOut,
        input aluPkg::flags_t wantFlags);
        a          = va;
        b          = vb;
        funSel     = vf;
        writeFlags = vw;
        #8;
        assert (aluOut === wantOut)
        else
        begin
            $display("[FAIL] %s aluOut expected %08h actual %08h", name, wantOut, aluOut);
            groupErrors++;
        end
        @(posedge Clock);
        #1;
        assert (flagsOut === wantFlags)
        else
        begin
            $display("[FAIL] %s flagsOut expected %04b actual %04b", name, wantFlags, flagsOut);
            groupErrors++;
        end
        vectorCount++;
    endtask

    task automatic reportTest(input string name);
        $display("test %-7s %s, %0d errors", name, (groupErrors == 0) ? "ok" : "bad", groupErrors);
        errorCount += groupErrors;
        groupErrors = 0;
    endtask

    initial
    begin
        int              g;
        int              base;
        logic [31:0]     randState;
        aluPkg::word_t   ra;
        aluPkg::word_t   rb;
        aluPkg::funSel_t rf;
        logic            rw;
        aluPkg::flags_t  modelFlags;
        aluPkg::flags_t  nextModel;

        Clock       = 1'b0;
        rstN        = 1'b0;
        a           = '0;
        b           = '0;
        funSel      = '0;
        writeFlags  = 1'b0;
        errorCount  = 0;
        groupErrors = 0;
        vectorCount = 0;
        groupName   = '{"reset", "arith", "logic", "shift", "strobe"};
        groupLast   = '{1, 12, 19, 27, 29};

        for (int i = 0; i < PatternCount*WordsPerLine; i++)
            patternMem[i] = 'x;
        $readmemh("bench/aluPatterns.hex", patternMem);
        if ($isunknown(patternMem[PatternCount*WordsPerLine-1]))
        begin
            $display("pattern file bench/aluPatterns.hex is missing or too short");
            groupErrors++;
        end

        repeat (ResetCycles) @(posedge Clock);
        #1;
        rstN = 1'b1;
        assert (flagsOut === 4'b0000)
        else
        begin
            $display("[FAIL] reset flagsOut expected 0000 actual %04b", flagsOut);
            groupErrors++;
        end

        // directed vectors, grouped by behavior
        g = 0;
        for (int i = 0; i < PatternCount; i++)
        begin
            base = i * WordsPerLine;
            applyVector($sformatf("%s vector %0d", groupName[g], i),
                patternMem[base], patternMem[base+1],
                aluPkg::funSel_t'(patternMem[base+2][4:0]), patternMem[base+3][0],
                patternMem[base+4], aluPkg::flags_t'(patternMem[base+5][3:0]));
            if (i == groupLast[g])
            begin
                reportTest(groupName[g]);
                g++;
            end
        end

        // model picks up from the last expected flags in the file
        modelFlags = aluPkg::flags_t'(patternMem[PatternCount*WordsPerLine-1][3:0]);
        randState  = Seed;
        for (int i = 0; i < RandomCount; i++)
        begin
            randState = xorshiftNext(randState);
            ra        = randState;
            randState = xorshiftNext(randState);
            rb        = randState;
            randState = xorshiftNext(randState);
            rf        = aluPkg::funSel_t'(randState[4:0]);
            rw        = randState[8] | randState[9];
            nextModel = rw ? expectedFlags(ra, rb, rf, modelFlags) : modelFlags;
            applyVector($sformatf("random vector %0d", i), ra, rb, rf, rw,
                expectedResult(ra, rb, rf, modelFlags.carry), nextModel);
            modelFlags = nextModel;
        end
        reportTest("random");

        $display("summary: %0d vectors run, %0d errors", vectorCount, errorCount);
        if (errorCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // one clock period per vector plus margin
    initial
    begin
        #((ResetCycles + PatternCount + RandomCount + 20) * 10);
        $display("simulation hung: the watchdog expired before all vectors finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+bench
logic/aluPkg.sv
logic/aluAdder.sv
logic/aluLogicUnit.sv
logic/aluShifter.sv
logic/aluControl.sv
logic/arithmeticLogicUnit.sv
bench/aluTb.sv

// File: logic/aluAdder.sv
/*
  Add, add with carry and subtract in 16 or 32 bits, purely combinational.
  For subtract the carry output is the unsigned borrow (A below B in the active width).
  Other operation codes give a result that the control module ignores.
*/
`timescale 1ns/1ps

module aluAdder
(
    input  aluPkg::word_t       a,
    input  aluPkg::word_t       b,
    input  logic                wide,
    input  aluPkg::aluOp_e      op,
    input  logic                carryIn,
    output aluPkg::unitResult_t sum
);

    localparam int WordWidth = aluPkg::WordWidth;
    localparam int HalfWidth = aluPkg::HalfWidth;

    aluPkg::word_t    opA;
    aluPkg::word_t    opB;
    logic [WordWidth:0] full;
    logic             subtract;
    logic             signA;
    logic             signB;
    logic             signR;

    always_comb
    begin
        subtract = (op == aluPkg::opSub);
        // narrow mode sees only the low halves
        opA = wide ? a : {{HalfWidth{1'b0}}, a[HalfWidth-1:0]};
        opB = wide ? b : {{HalfWidth{1'b0}}, b[HalfWidth-1:0]};

        if (subtract)
            full = {1'b0, opA} - {1'b0, opB};
        else
            full = {1'b0, opA} + {1'b0, opB} + (op == aluPkg::opAddCarry ? carryIn : 1'b0);

        sum.value = wide ? full[WordWidth-1:0]
                         : {{HalfWidth{1'b0}}, full[HalfWidth-1:0]};

        signA = wide ? a[WordWidth-1] : a[HalfWidth-1];
        signB = wide ? b[WordWidth-1] : b[HalfWidth-1];
        signR = wide ? full[WordWidth-1] : full[HalfWidth-1];

        // carry out of bit 16 or bit 32, borrow for subtract
        if (subtract)
            sum.carry = (opA < opB);
        else
            sum.carry = wide ? full[WordWidth] : full[HalfWidth];

        if (subtract)
            sum.overflow = (signA != signB) && (signR == signB);
        else
            sum.overflow = (signA == signB) && (signR != signA);

        sum.negative = signR;
    end

    narrowUpperZero: assert final (wide || sum.value[WordWidth-1:HalfWidth] == '0);

endmodule

// File: logic/aluControl.sv
/*
  Picks the datapath result for the current operation and keeps the Z/C/N/O flags.
  Flags load only on a clock edge with writeFlags high; reset is synchronous, active low.
  Carry and overflow are left alone by the pass, invert and bitwise operations.
*/
`timescale 1ns/1ps

module aluControl
(
    input  logic                Clock,
    input  logic                rstN,
    input  aluPkg::aluOp_e      op,
    input  logic                writeFlags,
    input  aluPkg::unitResult_t addResult,
    input  aluPkg::unitResult_t logicResult,
    input  aluPkg::unitResult_t shiftResult,
    output logic                carryIn,
    output aluPkg::word_t       result,
    output aluPkg::flags_t      flags
);

    logic                isArith;
    logic                isShift;
    aluPkg::unitResult_t selected;
    aluPkg::flags_t      nextFlags;

    // operation class
    always_comb
    begin
        isArith = 1'b0;
        isShift = 1'b0;
        case (op)
            aluPkg::opAdd, aluPkg::opAddCarry, aluPkg::opSub:
                isArith = 1'b1;
            aluPkg::opShiftLeft, aluPkg::opShiftRight, aluPkg::opShiftArith,
            aluPkg::opRotateLeft, aluPkg::opRotateRight:
                isShift = 1'b1;
            default:
                isArith = 1'b0;
        endcase
    end

    always_comb
    begin
        if (isArith)
            selected = addResult;
        else if (isShift)
            selected = shiftResult;
        else
            selected = logicResult;
    end

    assign result = selected.value;

    // value is already masked in narrow mode, so zero needs no width check
    always_comb
    begin
        nextFlags.zero     = (selected.value == '0);
        nextFlags.negative = selected.negative;
        nextFlags.carry    = (isArith || isShift) ? selected.carry : flags.carry;
        nextFlags.overflow = isArith ? selected.overflow : flags.overflow;
    end

    always_ff @(posedge Clock)
    begin
        if (!rstN)
            flags <= '0;
        else if (writeFlags)
            flags <= nextFlags;
    end

    // stored carry feeds add with carry and the rotates
    assign carryIn = flags.carry;

    flagsHoldWithoutStrobe: assert property (@(posedge Clock)
        rstN && !writeFlags |=> $stable(flags));

    flagsClearAfterReset: assert property (@(posedge Clock)
        !rstN |=> flags == '0);

endmodule

// File: logic/aluLogicUnit.sv
/*
  Pass, invert and bitwise operations in either width.
  Carry and overflow are always zero here; the control module keeps the stored ones.
*/
`timescale 1ns/1ps

module aluLogicUnit
(
    input  aluPkg::word_t       a,
    input  aluPkg::word_t       b,
    input  logic                wide,
    input  aluPkg::aluOp_e      op,
    output aluPkg::unitResult_t out
);

    localparam int HalfWidth = aluPkg::HalfWidth;

    aluPkg::word_t raw;

    always_comb
    begin
        case (op)
            aluPkg::opPassA: raw = a;
            aluPkg::opPassB: raw = b;
            aluPkg::opNotA:  raw = ~a;
            aluPkg::opNotB:  raw = ~b;
            aluPkg::opAnd:   raw = a & b;
            aluPkg::opOr:    raw = a | b;
            aluPkg::opXor:   raw = a ^ b;
            aluPkg::opNand:  raw = ~(a & b);
            // arithmetic and shift codes belong to the other units
            default:         raw = '0;
        endcase

        out.value    = wide ? raw : {{HalfWidth{1'b0}}, raw[HalfWidth-1:0]};
        out.negative = wide ? raw[aluPkg::WordWidth-1] : raw[HalfWidth-1];
        out.carry    = 1'b0;
        out.overflow = 1'b0;
    end

endmodule

// File: logic/aluPkg.sv
/*
  Shared widths, operation codes and structs for the ALU.
  Operation codes follow the original 4-bit encoding, pass A at 0 up to rotate right at 15.
  Narrow mode works on the low HalfWidth bits and always returns a zero upper half.
*/
package aluPkg;

    localparam int WordWidth = 32;
    localparam int HalfWidth = 16;

    typedef logic [WordWidth-1:0] word_t;

    // code order matches the existing function select
    typedef enum logic [3:0] {
        opPassA       = 4'd0,
        opPassB       = 4'd1,
        opNotA        = 4'd2,
        opNotB        = 4'd3,
        opAdd         = 4'd4,
        opAddCarry    = 4'd5,
        opSub         = 4'd6,
        opAnd         = 4'd7,
        opOr          = 4'd8,
        opXor         = 4'd9,
        opNand        = 4'd10,
        opShiftLeft   = 4'd11,
        opShiftRight  = 4'd12,
        opShiftArith  = 4'd13,
        opRotateLeft  = 4'd14,
        opRotateRight = 4'd15
    } aluOp_e;

    // wide in the top bit, 1 selects 32-bit mode
    typedef struct packed {
        logic   wide;
        aluOp_e op;
    } funSel_t;

    // high to low: Z, C, N, O
    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
        logic overflow;
    } flags_t;

    // what each datapath unit hands to the control module
    typedef struct packed {
        word_t value;
        logic  carry;
        logic  overflow;
        logic  negative;
    } unitResult_t;

endpackage

// File: logic/aluShifter.sv
/*
  One-bit shifts and rotates through carry within the active width.
  Carry out is the bit moved out: top bit for left moves, bit 0 for right moves.
  Rotate right puts the stored carry into bit 15 in narrow mode, bit 31 in wide mode.
*/
`timescale 1ns/1ps

module aluShifter
(
    input  aluPkg::word_t       a,
    input  logic                wide,
    input  aluPkg::aluOp_e      op,
    input  logic                carryIn,
    output aluPkg::unitResult_t out
);

    localparam int WordWidth = aluPkg::WordWidth;
    localparam int HalfWidth = aluPkg::HalfWidth;

    aluPkg::word_t maskedA;
    aluPkg::word_t leftMove;
    aluPkg::word_t rightMove;
    aluPkg::word_t moved;
    logic          topBit;
    logic          fillBit;
    logic          isLeft;

    always_comb
    begin
        maskedA = wide ? a : {{HalfWidth{1'b0}}, a[HalfWidth-1:0]};
        topBit  = wide ? a[WordWidth-1] : a[HalfWidth-1];
        isLeft  = (op == aluPkg::opShiftLeft) || (op == aluPkg::opRotateLeft);

        // bits pushed above bit 15 are dropped by the final mask
        leftMove = {a[WordWidth-2:0], (op == aluPkg::opRotateLeft) ? carryIn : 1'b0};

        case (op)
            aluPkg::opShiftArith:  fillBit = topBit;
            aluPkg::opRotateRight: fillBit = carryIn;
            default:               fillBit = 1'b0;
        endcase

        // fill goes in at the top of the active width
        rightMove = maskedA >> 1;
        if (wide)
            rightMove[WordWidth-1] = fillBit;
        else
            rightMove[HalfWidth-1] = fillBit;

        case (op)
            aluPkg::opShiftLeft, aluPkg::opRotateLeft:
                moved = leftMove;
            aluPkg::opShiftRight, aluPkg::opShiftArith, aluPkg::opRotateRight:
                moved = rightMove;
            default:
                moved = '0;
        endcase

        out.value    = wide ? moved : {{HalfWidth{1'b0}}, moved[HalfWidth-1:0]};
        out.negative = wide ? moved[WordWidth-1] : moved[HalfWidth-1];
        out.carry    = isLeft ? topBit : a[0];
        out.overflow = 1'b0;
    end

endmodule

// File: logic/arithmeticLogicUnit.sv
/*
  ALU top level: combinational result, registered Z/C/N/O flags.
  funSel.wide set selects 32-bit mode; clear gives 16-bit mode with a zero upper half.
  writeFlags is a one-cycle strobe and is always taken.
*/
`timescale 1ns/1ps

module arithmeticLogicUnit
(
    input  logic            Clock,
    input  logic            rstN,
    input  aluPkg::word_t   a,
    input  aluPkg::word_t   b,
    input  aluPkg::funSel_t funSel,
    input  logic            writeFlags,
    output aluPkg::word_t   aluOut,
    output aluPkg::flags_t  flagsOut
);

    aluPkg::unitResult_t addResult;
    aluPkg::unitResult_t logicResult;
    aluPkg::unitResult_t shiftResult;
    logic                carryIn;

    aluAdder adder_i
    (
        .a       (a),
        .b       (b),
        .wide    (funSel.wide),
        .op      (funSel.op),
        .carryIn (carryIn),
        .sum     (addResult)
    );

    aluLogicUnit logicUnit_i
    (
        .a    (a),
        .b    (b),
        .wide (funSel.wide),
        .op   (funSel.op),
        .out  (logicResult)
    );

    aluShifter shifter_i
    (
        .a       (a),
        .wide    (funSel.wide),
        .op      (funSel.op),
        .carryIn (carryIn),
        .out     (shiftResult)
    );

    // selects the result and owns the flag register
    aluControl control_i
    (
        .Clock       (Clock),
        .rstN        (rstN),
        .op          (funSel.op),
        .writeFlags  (writeFlags),
        .addResult   (addResult),
        .logicResult (logicResult),
        .shiftResult (shiftResult),
        .carryIn     (carryIn),
        .result      (aluOut),
        .flags       (flagsOut)
    );

endmodule
